// File: rcfg_stim.txt
// Columns, all hex: op (0 read, 1 write), address, writedata,
// status {pwrdn, avmm_busy, cal_busy, locked}, expected readdata, expected powerdown
// Channel writes and read-back on all three channels
1 010 deadbea5 1 00000000 0
1 410 0000013c 1 00000000 0
1 810 ffffff96 1 00000000 0
0 010 00000000 1 000000a5 0
0 410 00000000 1 0000003c 0
0 810 00000000 1 00000096 0
1 9a3 000000c7 1 00000000 0
0 9a3 00000000 1 000000c7 0
// Channel isolation
1 010 00000011 1 00000000 0
0 410 00000000 1 0000003c 0
0 810 00000000 1 00000096 0
0 010 00000000 1 00000011 0
// Status readback and unknown offset
0 200 00000000 6 00000006 0
0 200 00000000 f 0000000f 1
0 200 00000000 a 0000000a 1
0 2f0 00000000 1 00000000 0
// Powerdown override
1 201 00000001 0 00000000 0
0 201 00000000 8 00000001 0
1 201 00000003 8 00000000 1
0 200 00000000 1 00000001 1
1 201 00000002 1 00000000 0
0 201 00000000 9 00000002 1
1 201 00000003 1 00000000 1
// Unmapped select, no side effects
1 c10 00000077 1 00000000 1
0 c10 00000000 1 00000000 1
1 e01 00000000 1 00000000 1
0 201 00000000 1 00000003 1
0 010 00000000 1 00000011 1
0 410 00000000 1 0000003c 1
// Write to an unknown CSR offset is dropped
1 2f0 000000ff 0 00000000 1
0 201 00000000 0 00000003 1
1 201 00000000 0 00000000 0

// File: sources.f
rcfg_bus_pkg.sv
pll_csr_pkg.sv
rcfg_addr_decode.sv
rcfg_chnl_access.sv
pll_soft_csr.sv
rcfg_read_return.sv
pll_rcfg_bridge.sv
tb_rcfg_checker.sv
tb_pll_rcfg_bridge.sv

// File: Bender.yml
package:
  name: pll_rcfg_bridge

sources:
  - rcfg_bus_pkg.sv
  - pll_csr_pkg.sv
  - rcfg_addr_decode.sv
  - rcfg_chnl_access.sv
  - pll_soft_csr.sv
  - rcfg_read_return.sv
  - pll_rcfg_bridge.sv
  - target: test
    files:
      - tb_rcfg_checker.sv
      - tb_pll_rcfg_bridge.sv

// File: tb_pll_rcfg_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top for the PLL reconfiguration bridge
// Clock, reset, stimulus from the stim file, channel memory models
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pll_rcfg_bridge import rcfg_bus_pkg::*; ();

  localparam int CLK_HALF       = 4;
  localparam int FIELDS         = 6;
  localparam int MAX_LINES      = 64;
  localparam int SETTLE_CYCLES  = 4;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int MEM_DEPTH      = 1024;

  logic                                  reconfig_clk;
  logic                                  rst;
  logic                                  reconfig_read;
  logic                                  reconfig_write;
  rcfg_addr_t                            reconfig_address;
  rcfg_data_t                            reconfig_writedata;
  rcfg_data_t                            reconfig_readdata;
  logic                                  reconfig_waitrequest;
  logic       [NUM_CHNL-1:0]             avmm_read;
  logic       [NUM_CHNL-1:0]             avmm_write;
  chnl_addr_t [NUM_CHNL-1:0]             avmm_address;
  chnl_data_t [NUM_CHNL-1:0]             avmm_writedata;
  wire        [NUM_CHNL-1:0][CHNL_DATA_WIDTH-1:0] avmm_readdata;
  wire        [NUM_CHNL-1:0]             avmm_waitrequest;
  logic                                  in_pll_powerdown;
  logic                                  in_pll_locked;
  logic                                  in_pll_cal_busy;
  logic                                  in_avmm_busy;
  logic                                  out_pll_powerdown;

  // Expected values handed to the checker
  int         test_id;
  rcfg_data_t exp_rdata;
  logic       exp_pd;
  int         test_count;
  int         error_count;

  logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
  chnl_data_t  chnl_mem [0:NUM_CHNL-1][0:MEM_DEPTH-1];
  logic [1:0]  wait_left [0:NUM_CHNL-1];
  integer      seed = 81579;
  logic        timed_out;
  int          line_count;

  initial reconfig_clk = 1'b0;
  always #CLK_HALF reconfig_clk = ~reconfig_clk;

  pll_rcfg_bridge i_pll_rcfg_bridge (
    .reconfig_clk         (reconfig_clk),
    .rst                  (rst),
    .reconfig_read        (reconfig_read),
    .reconfig_write       (reconfig_write),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .avmm_read            (avmm_read),
    .avmm_write           (avmm_write),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_readdata        (avmm_readdata),
    .avmm_waitrequest     (avmm_waitrequest),
    .in_pll_powerdown     (in_pll_powerdown),
    .in_pll_locked        (in_pll_locked),
    .in_pll_cal_busy      (in_pll_cal_busy),
    .in_avmm_busy         (in_avmm_busy),
    .out_pll_powerdown    (out_pll_powerdown)
  );

  tb_rcfg_checker i_rcfg_checker (
    .reconfig_clk         (reconfig_clk),
    .rst                  (rst),
    .reconfig_read        (reconfig_read),
    .reconfig_write       (reconfig_write),
    .reconfig_address     (reconfig_address),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .out_pll_powerdown    (out_pll_powerdown),
    .test_id              (test_id),
    .exp_rdata            (exp_rdata),
    .exp_pd               (exp_pd),
    .test_count           (test_count),
    .error_count          (error_count)
  );

  // Channel models, wait count is loaded ahead of each access
  genvar c;
  for (c = 0; c < NUM_CHNL; c++) begin : g_chnl_model
    assign avmm_waitrequest[c] = (wait_left[c] != 2'd0);
    assign avmm_readdata[c]    = chnl_mem[c][avmm_address[c]];
  end

  initial begin
    for (int ch = 0; ch < NUM_CHNL; ch++) begin
      wait_left[ch] = 2'($random(seed));
      for (int a = 0; a < MEM_DEPTH; a++) begin
        chnl_mem[ch][a] = 8'(a) ^ 8'(a >> 2) ^ 8'(ch << 6);
      end
    end
  end

  always @(posedge reconfig_clk) begin
    for (int ch = 0; ch < NUM_CHNL; ch++) begin
      if (avmm_read[ch] || avmm_write[ch]) begin
        if (wait_left[ch] != 2'd0) begin
          wait_left[ch] <= wait_left[ch] - 2'd1;
        end else begin
          if (avmm_write[ch]) begin
            chnl_mem[ch][avmm_address[ch]] <= avmm_writedata[ch];
          end
          wait_left[ch] <= 2'($random(seed));
        end
      end
    end
  end

  // One stim line: status inputs, settle, then one held user access
  task automatic run_line(input int idx);
    logic [31:0] op;
    logic [31:0] stat;
    int          waited;
    logic        done;
    op               = stim_mem[idx*FIELDS];
    stat             = stim_mem[idx*FIELDS+3];
    in_pll_locked    = stat[0];
    in_pll_cal_busy  = stat[1];
    in_avmm_busy     = stat[2];
    in_pll_powerdown = stat[3];
    test_id          = idx + 1;
    exp_rdata        = stim_mem[idx*FIELDS+4];
    exp_pd           = stim_mem[idx*FIELDS+5][0];
    repeat (SETTLE_CYCLES) @(posedge reconfig_clk);
    #1;
    reconfig_read      = (op == 32'd0);
    reconfig_write     = (op == 32'd1);
    reconfig_address   = rcfg_addr_t'(stim_mem[idx*FIELDS+1]);
    reconfig_writedata = stim_mem[idx*FIELDS+2];
    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT_CYCLES) begin
      @(negedge reconfig_clk);
      if (!reconfig_waitrequest) begin
        done = 1'b1;
      end else begin
        waited++;
      end
    end
    if (done) begin
      @(posedge reconfig_clk);
      #1;
    end else begin
      $display("Timeout: test %0d got no completion within %0d cycles",
               test_id, TIMEOUT_CYCLES);
      timed_out = 1'b1;
    end
    reconfig_read  = 1'b0;
    reconfig_write = 1'b0;
  endtask

  initial begin
    int idx;
    rst                = 1'b1;
    reconfig_read      = 1'b0;
    reconfig_write     = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    in_pll_powerdown   = 1'b0;
    in_pll_locked      = 1'b0;
    in_pll_cal_busy    = 1'b0;
    in_avmm_busy       = 1'b0;
    test_id            = 0;
    exp_rdata          = '0;
    exp_pd             = 1'b0;
    timed_out          = 1'b0;
    line_count         = 0;
    $readmemh("rcfg_stim.txt", stim_mem);
    repeat (2) @(posedge reconfig_clk);
    #1;
    rst = 1'b0;
    idx = 0;
    while (idx < MAX_LINES && !timed_out && !$isunknown(stim_mem[idx*FIELDS])) begin
      run_line(idx);
      idx++;
    end
    line_count = idx;
    repeat (4) @(posedge reconfig_clk);
    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (timed_out || line_count == 0 || error_count != 0 || test_count != line_count) begin
      if (line_count == 0) begin
        $display("No stimulus lines were read from rcfg_stim.txt");
      end else if (!timed_out && test_count != line_count) begin
        $display("Only %0d of %0d accesses completed", test_count, line_count);
      end
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

// File: tb_rcfg_checker.sv
////////////////////////////////////////////////////////////////////////////
// Completion checker of the reconfiguration bridge testbench
// Watches the user port and the powerdown output, compares every
// completed access with its expected values and counts the results
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rcfg_checker import rcfg_bus_pkg::*; (
  input  logic       reconfig_clk,
  input  logic       rst,
  input  logic       reconfig_read,
  input  logic       reconfig_write,
  input  rcfg_addr_t reconfig_address,
  input  rcfg_data_t reconfig_readdata,
  input  logic       reconfig_waitrequest,
  input  logic       out_pll_powerdown,
  input  int         test_id,
  input  rcfg_data_t exp_rdata,
  input  logic       exp_pd,
  output int         test_count,
  output int         error_count
);

  // Wait cycles ahead of the completion for CSR and unmapped accesses
  localparam int FIXED_WAIT = 3;

  int wait_cycles;

  initial begin
    test_count  = 0;
    error_count = 0;
    wait_cycles = 0;
  end

  task automatic check_completion();
    logic    ok;
    logic    fixed_latency;
    if_sel_t sel;
    ok            = 1'b1;
    sel           = reconfig_address[RCFG_ADDR_BITS-1 -: IF_SEL_BITS];
    fixed_latency = reconfig_address[CSR_SEL_BIT] || (int'(sel) >= NUM_CHNL);
    if (reconfig_read && reconfig_readdata !== exp_rdata) begin
      $display("Error at %0d ns: test %0d read 0x%08h, expected 0x%08h",
               $time, test_id, reconfig_readdata, exp_rdata);
      error_count++;
      ok = 1'b0;
    end
    if (out_pll_powerdown !== exp_pd) begin
      $display("Error at %0d ns: test %0d out_pll_powerdown %b, expected %b",
               $time, test_id, out_pll_powerdown, exp_pd);
      error_count++;
      ok = 1'b0;
    end
    if (fixed_latency && wait_cycles != FIXED_WAIT) begin
      $display("Error at %0d ns: test %0d took %0d wait cycles, expected %0d",
               $time, test_id, wait_cycles, FIXED_WAIT);
      error_count++;
      ok = 1'b0;
    end
    test_count++;
    $display("Test %0d: %s 0x%03h after %0d wait cycles, %s", test_id,
             reconfig_write ? "write" : "read", reconfig_address, wait_cycles,
             ok ? "ok" : "mismatch");
  endtask

  // Mid-cycle sampling, inputs and outputs are settled here
  always @(negedge reconfig_clk) begin
    if (!rst) begin
      if (reconfig_read || reconfig_write) begin
        if (reconfig_waitrequest) begin
          wait_cycles++;
        end else begin
          check_completion();
          wait_cycles = 0;
        end
      end else if (!reconfig_waitrequest) begin
        $display("Error at %0d ns: waitrequest low with no access pending", $time);
        error_count++;
      end
    end
  end

endmodule

// File: pll_rcfg_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the PLL reconfiguration bridge
// Shared user port decode, channel and CSR execute, read return
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pll_rcfg_bridge import rcfg_bus_pkg::*; (
  input  logic                       reconfig_clk,
  input  logic                       rst,
  input  logic                       reconfig_read,
  input  logic                       reconfig_write,
  input  rcfg_addr_t                 reconfig_address,
  input  rcfg_data_t                 reconfig_writedata,
  output rcfg_data_t                 reconfig_readdata,
  output logic                       reconfig_waitrequest,
  output logic       [NUM_CHNL-1:0]  avmm_read,
  output logic       [NUM_CHNL-1:0]  avmm_write,
  output chnl_addr_t [NUM_CHNL-1:0]  avmm_address,
  output chnl_data_t [NUM_CHNL-1:0]  avmm_writedata,
  input  chnl_data_t [NUM_CHNL-1:0]  avmm_readdata,
  input  logic       [NUM_CHNL-1:0]  avmm_waitrequest,
  input  logic                       in_pll_powerdown,
  input  logic                       in_pll_locked,
  input  logic                       in_pll_cal_busy,
  input  logic                       in_avmm_busy,
  output logic                       out_pll_powerdown
);

  // Decoded request
  logic       req_valid;
  logic       req_write;
  if_sel_t    req_sel;
  chnl_addr_t req_addr;
  chnl_data_t req_wdata;
  logic       req_csr;
  logic       req_unmapped;

  // Completions towards the result stage
  logic       chnl_done;
  chnl_data_t chnl_rdata;
  logic       csr_done;
  chnl_data_t csr_rdata;
  logic       unmapped_done;
  logic       access_end;

  rcfg_addr_decode i_rcfg_addr_decode (
    .reconfig_clk       (reconfig_clk),
    .rst                (rst),
    .reconfig_read      (reconfig_read),
    .reconfig_write     (reconfig_write),
    .reconfig_address   (reconfig_address),
    .reconfig_writedata (reconfig_writedata),
    .access_end         (access_end),
    .req_valid          (req_valid),
    .req_write          (req_write),
    .req_sel            (req_sel),
    .req_addr           (req_addr),
    .req_wdata          (req_wdata),
    .req_csr            (req_csr),
    .req_unmapped       (req_unmapped),
    .unmapped_done      (unmapped_done)
  );

  rcfg_chnl_access i_rcfg_chnl_access (
    .reconfig_clk     (reconfig_clk),
    .rst              (rst),
    .req_valid        (req_valid),
    .req_write        (req_write),
    .req_sel          (req_sel),
    .req_addr         (req_addr),
    .req_wdata        (req_wdata),
    .req_csr          (req_csr),
    .req_unmapped     (req_unmapped),
    .avmm_readdata    (avmm_readdata),
    .avmm_waitrequest (avmm_waitrequest),
    .avmm_read        (avmm_read),
    .avmm_write       (avmm_write),
    .avmm_address     (avmm_address),
    .avmm_writedata   (avmm_writedata),
    .chnl_done        (chnl_done),
    .chnl_rdata       (chnl_rdata)
  );

  pll_soft_csr i_pll_soft_csr (
    .reconfig_clk      (reconfig_clk),
    .rst               (rst),
    .req_valid         (req_valid),
    .req_write         (req_write),
    .req_csr           (req_csr),
    .req_unmapped      (req_unmapped),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .in_pll_powerdown  (in_pll_powerdown),
    .in_pll_locked     (in_pll_locked),
    .in_pll_cal_busy   (in_pll_cal_busy),
    .in_avmm_busy      (in_avmm_busy),
    .csr_done          (csr_done),
    .csr_rdata         (csr_rdata),
    .out_pll_powerdown (out_pll_powerdown)
  );

  rcfg_read_return i_rcfg_read_return (
    .reconfig_clk         (reconfig_clk),
    .rst                  (rst),
    .chnl_done            (chnl_done),
    .chnl_rdata           (chnl_rdata),
    .csr_done             (csr_done),
    .csr_rdata            (csr_rdata),
    .unmapped_done        (unmapped_done),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .access_end           (access_end)
  );

endmodule

// File: rcfg_read_return.sv
////////////////////////////////////////////////////////////////////////////
// Result stage of the reconfiguration bridge
// Registers the completing byte and releases the user waitrequest
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rcfg_read_return
  import rcfg_bus_pkg::*;
  import pll_csr_pkg::*;
(
  input  logic       reconfig_clk,
  input  logic       rst,
  input  logic       chnl_done,
  input  chnl_data_t chnl_rdata,
  input  logic       csr_done,
  input  csr_byte_t  csr_rdata,
  input  logic       unmapped_done,
  output rcfg_data_t reconfig_readdata,
  output logic       reconfig_waitrequest,
  output logic       access_end
);

  logic       done_q;
  chnl_data_t rdata_q;
  chnl_data_t rdata_sel;

  // Unmapped selects read back as zero
  always_comb begin
    if (chnl_done) begin
      rdata_sel = chnl_rdata;
    end else if (csr_done) begin
      rdata_sel = csr_rdata;
    end else begin
      rdata_sel = '0;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= chnl_done | csr_done | unmapped_done;
    end
  end

  always_ff @(posedge reconfig_clk) begin
    rdata_q <= rdata_sel;
  end

  assign reconfig_readdata    = rcfg_data_t'(rdata_q);
  // Waitrequest drops for exactly the completion cycle
  assign reconfig_waitrequest = ~done_q;
  assign access_end           = done_q;

endmodule

// File: pll_soft_csr.sv
////////////////////////////////////////////////////////////////////////////
// Soft CSR of the PLL
// Synchronized status readback, control register and the
// powerdown override
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pll_soft_csr
  import rcfg_bus_pkg::*;
  import pll_csr_pkg::*;
(
  input  logic       reconfig_clk,
  input  logic       rst,
  input  logic       req_valid,
  input  logic       req_write,
  input  logic       req_csr,
  input  logic       req_unmapped,
  input  chnl_addr_t req_addr,
  input  chnl_data_t req_wdata,
  input  logic       in_pll_powerdown,
  input  logic       in_pll_locked,
  input  logic       in_pll_cal_busy,
  input  logic       in_avmm_busy,
  output logic       csr_done,
  output csr_byte_t  csr_rdata,
  output logic       out_pll_powerdown
);

  logic [3:0]  stat_meta;
  logic [3:0]  stat_sync;
  csr_byte_t   status;
  csr_byte_t   ctrl_q;
  csr_offset_t offset;
  logic        hit;

  assign hit    = req_valid & req_csr & ~req_unmapped;
  assign offset = req_addr[CSR_OFFSET_BITS-1:0];

  // Two-flop synchronizer for the asynchronous status inputs
  always_ff @(posedge reconfig_clk) begin
    stat_meta <= {in_pll_powerdown, in_avmm_busy, in_pll_cal_busy, in_pll_locked};
    stat_sync <= stat_meta;
  end

  always_comb begin
    status                     = '0;
    status[STAT_LOCKED_BIT]    = stat_sync[0];
    status[STAT_CAL_BUSY_BIT]  = stat_sync[1];
    status[STAT_AVMM_BUSY_BIT] = stat_sync[2];
    status[STAT_PWRDN_BIT]     = stat_sync[3];
  end

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      ctrl_q   <= '0;
      csr_done <= 1'b0;
    end else begin
      csr_done <= hit;
      // Writes elsewhere in the window are dropped
      if (hit && req_write && offset == CSR_CTRL_OFFSET) begin
        ctrl_q[CTRL_OVR_EN_BIT]  <= req_wdata[CTRL_OVR_EN_BIT];
        ctrl_q[CTRL_OVR_VAL_BIT] <= req_wdata[CTRL_OVR_VAL_BIT];
      end
    end
  end

  always_ff @(posedge reconfig_clk) begin
    if (hit) begin
      case (offset)
        CSR_STATUS_OFFSET: csr_rdata <= status;
        CSR_CTRL_OFFSET:   csr_rdata <= ctrl_q;
        default:           csr_rdata <= '0;
      endcase
    end
  end

  // Override replaces the core's powerdown request
  assign out_pll_powerdown = ctrl_q[CTRL_OVR_EN_BIT] ? ctrl_q[CTRL_OVR_VAL_BIT]
                                                     : in_pll_powerdown;

endmodule

// File: rcfg_chnl_access.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage towards the transceiver channels
// Drives the selected channel's 8-bit port, holds it through
// waitrequest and returns the captured read byte
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rcfg_chnl_access import rcfg_bus_pkg::*; (
  input  logic                       reconfig_clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  logic                       req_write,
  input  if_sel_t                    req_sel,
  input  chnl_addr_t                 req_addr,
  input  chnl_data_t                 req_wdata,
  input  logic                       req_csr,
  input  logic                       req_unmapped,
  input  chnl_data_t [NUM_CHNL-1:0]  avmm_readdata,
  input  logic       [NUM_CHNL-1:0]  avmm_waitrequest,
  output logic       [NUM_CHNL-1:0]  avmm_read,
  output logic       [NUM_CHNL-1:0]  avmm_write,
  output chnl_addr_t [NUM_CHNL-1:0]  avmm_address,
  output chnl_data_t [NUM_CHNL-1:0]  avmm_writedata,
  output logic                       chnl_done,
  output chnl_data_t                 chnl_rdata
);

  chnl_state_t state_q;
  if_sel_t     sel_q;
  chnl_addr_t  addr_q;
  chnl_data_t  wdata_q;
  logic        start;
  logic        accepted;

  // Only accesses that reach a real channel port
  assign start    = req_valid & ~req_csr & ~req_unmapped;
  assign accepted = (state_q == ST_ACCESS) & ~avmm_waitrequest[sel_q];

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      avmm_read  <= '0;
      avmm_write <= '0;
      chnl_done  <= 1'b0;
    end else begin
      // Extra stage so the result lands in step with the CSR path
      chnl_done <= (state_q == ST_DONE);
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            avmm_read[req_sel]  <= ~req_write;
            avmm_write[req_sel] <= req_write;
            state_q             <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          // Strobes stay up until the channel stops waiting
          if (accepted) begin
            avmm_read  <= '0;
            avmm_write <= '0;
            state_q    <= ST_DONE;
          end
        end
        ST_DONE: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Access fields and returned byte
  always_ff @(posedge reconfig_clk) begin
    if (start && state_q == ST_IDLE) begin
      sel_q   <= req_sel;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if (accepted) begin
      chnl_rdata <= avmm_readdata[sel_q];
    end
  end

  // Address and data go to every channel, the strobes pick one
  always_comb begin
    for (int i = 0; i < NUM_CHNL; i++) begin
      avmm_address[i]   = addr_q;
      avmm_writedata[i] = wdata_q;
    end
  end

endmodule

// File: rcfg_addr_decode.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage of the reconfiguration bridge
// Captures one user request at a time and splits the shared address
// into channel index, channel address, CSR hit and unmapped flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rcfg_addr_decode import rcfg_bus_pkg::*; (
  input  logic       reconfig_clk,
  input  logic       rst,
  input  logic       reconfig_read,
  input  logic       reconfig_write,
  input  rcfg_addr_t reconfig_address,
  input  rcfg_data_t reconfig_writedata,
  input  logic       access_end,
  output logic       req_valid,
  output logic       req_write,
  output if_sel_t    req_sel,
  output chnl_addr_t req_addr,
  output chnl_data_t req_wdata,
  output logic       req_csr,
  output logic       req_unmapped,
  output logic       unmapped_done
);

  logic    busy_q;
  logic    start;
  if_sel_t addr_sel;

  // A held request starts only once until the result stage frees us
  assign start    = (reconfig_read | reconfig_write) & ~busy_q;
  assign addr_sel = reconfig_address[RCFG_ADDR_BITS-1 -: IF_SEL_BITS];

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      busy_q        <= 1'b0;
      req_valid     <= 1'b0;
      unmapped_done <= 1'b0;
    end else begin
      req_valid     <= start;
      // Nothing to execute for an unmapped select, finish next cycle
      unmapped_done <= req_valid & req_unmapped;
      if (start) begin
        busy_q <= 1'b1;
      end else if (access_end) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request fields
  always_ff @(posedge reconfig_clk) begin
    if (start) begin
      req_write    <= reconfig_write;
      req_sel      <= addr_sel;
      req_addr     <= reconfig_address[CHNL_ADDR_BITS-1:0];
      req_wdata    <= reconfig_writedata[CHNL_DATA_WIDTH-1:0];
      req_csr      <= reconfig_address[CSR_SEL_BIT];
      req_unmapped <= (addr_sel >= if_sel_t'(NUM_CHNL));
    end
  end

endmodule

// File: pll_csr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Soft CSR definitions
// Register offsets, status and control bit positions, register types
////////////////////////////////////////////////////////////////////////////

package pll_csr_pkg;

  localparam int unsigned CSR_OFFSET_BITS = 9;
  localparam int unsigned CSR_BYTE_BITS   = 8;

  typedef logic [CSR_OFFSET_BITS-1:0] csr_offset_t;
  typedef logic [CSR_BYTE_BITS-1:0]   csr_byte_t;

  // Register offsets inside the CSR window
  localparam csr_offset_t CSR_STATUS_OFFSET = 9'h000;
  localparam csr_offset_t CSR_CTRL_OFFSET   = 9'h001;

  // Status register fields
  localparam int unsigned STAT_LOCKED_BIT    = 0;
  localparam int unsigned STAT_CAL_BUSY_BIT  = 1;
  localparam int unsigned STAT_AVMM_BUSY_BIT = 2;
  localparam int unsigned STAT_PWRDN_BIT     = 3;

  // Control register fields
  localparam int unsigned CTRL_OVR_EN_BIT  = 0;
  localparam int unsigned CTRL_OVR_VAL_BIT = 1;

endpackage

// File: rcfg_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared reconfiguration bus definitions
// Bus and channel widths, shared address map, interface select type
// and the channel access state machine encoding
////////////////////////////////////////////////////////////////////////////

package rcfg_bus_pkg;

  // Channel interfaces behind the shared port
  localparam int unsigned NUM_CHNL = 3;

  // Address map of the shared port
  localparam int unsigned CHNL_ADDR_BITS = 10;
  localparam int unsigned IF_SEL_BITS    = 2;
  localparam int unsigned RCFG_ADDR_BITS = CHNL_ADDR_BITS + IF_SEL_BITS;

  // Data widths on the user and transceiver sides
  localparam int unsigned DATA_WIDTH      = 32;
  localparam int unsigned CHNL_DATA_WIDTH = 8;

  // Channel address bit that steers an access to the soft CSR
  localparam int unsigned CSR_SEL_BIT = 9;

  typedef logic [RCFG_ADDR_BITS-1:0]  rcfg_addr_t;
  typedef logic [CHNL_ADDR_BITS-1:0]  chnl_addr_t;
  typedef logic [IF_SEL_BITS-1:0]     if_sel_t;
  typedef logic [DATA_WIDTH-1:0]      rcfg_data_t;
  typedef logic [CHNL_DATA_WIDTH-1:0] chnl_data_t;

  // Channel access FSM
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_DONE   = 2'd2
  } chnl_state_t;

endpackage
